// File: ma_pkg.sv
package ma_pkg;

    // basic widths
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int REG_IDX_W  = 5;
    localparam int REG_COUNT  = 32;
    localparam int BYTE_LANES = DATA_W / 8;

    // data memory depth in words
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [MEM_IDX_W-1:0]  mem_idx_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // codes kept compatible with the older rw_e field
    typedef enum logic [1:0] {
        ACC_NONE   = 2'b00,
        ACC_STORE  = 2'b01,
        ACC_LOAD_S = 2'b10,
        ACC_LOAD_U = 2'b11
    } acc_kind_e;

    // 2'b10 is not a legal length
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_BAD  = 2'b10,
        SZ_WORD = 2'b11
    } acc_size_e;

    typedef enum logic [2:0] {
        MA_IDLE,
        MA_ACCESS,
        MA_RESULT,
        MA_WAIT_ACK,
        MA_WAIT_UP
    } ma_state_e;

    // execute to memory-access record
    typedef struct packed {
        acc_kind_e kind;
        acc_size_e size;
        reg_idx_t  rd;
        logic      wb_en;
        addr_t     ans;
        data_t     din;
    } ex_ma_t;

    // memory-access to writeback record
    typedef struct packed {
        logic     wb_en;
        reg_idx_t rd;
        data_t    value;
    } ma_wb_t;

endpackage

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem import ma_pkg::*; (
    input  logic     clk,
    input  logic     mem_en,
    input  logic     mem_we,
    input  mem_idx_t mem_idx,
    input  byte_en_t mem_be,
    input  data_t    mem_wdata,
    output data_t    mem_rdata
);

    // word-organised storage, lane 0 is the lowest byte address
    data_t mem [MEM_WORDS];

    // byte-lane writes
    always_ff @(posedge clk) begin
        if (mem_en && mem_we) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (mem_be[lane]) begin
                    mem[mem_idx][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // registered read, holds its value until the next enabled read
    always_ff @(posedge clk) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_idx];
        end
    end

endmodule

// File: ma_stage.sv
`timescale 1ns/1ps

module ma_stage import ma_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // upstream four-phase link
    input  logic     up_syn,
    input  ex_ma_t   up_rec,
    output logic     up_ack,

    // downstream four-phase link
    output logic     down_syn,
    output ma_wb_t   down_rec,
    input  logic     down_ack,

    // data memory port
    output logic     mem_en,
    output logic     mem_we,
    output mem_idx_t mem_idx,
    output byte_en_t mem_be,
    output data_t    mem_wdata,
    input  data_t    mem_rdata,

    output logic     access_err
);

    ma_state_e  state;
    ex_ma_t     cur_rec;
    logic       accept;
    logic       is_mem;
    logic       misaligned;
    logic       acc_err_c;
    logic       mem_go;
    logic       load_signed;
    logic       wb_en_c;
    logic [1:0] byte_off;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    byte_en_t   be_c;
    data_t      wdata_c;
    data_t      load_val;
    data_t      wb_val;

    // new item only when idle and the previous ack is gone
    assign accept = (state == MA_IDLE) && up_syn && !up_ack;

    assign is_mem   = (cur_rec.kind != ACC_NONE);
    assign byte_off = cur_rec.ans[1:0];

    // alignment and length check
    always_comb begin
        case (cur_rec.size)
            SZ_BYTE: misaligned = 1'b0;
            SZ_HALF: misaligned = byte_off[0];
            SZ_WORD: misaligned = |byte_off;
            default: misaligned = 1'b1;
        endcase
    end

    assign acc_err_c = is_mem && misaligned;

    // lane mask and store data replicated across the lanes
    always_comb begin
        case (cur_rec.size)
            SZ_BYTE: begin
                be_c    = byte_en_t'(1) << byte_off;
                wdata_c = {4{cur_rec.din[7:0]}};
            end
            SZ_HALF: begin
                be_c    = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata_c = {2{cur_rec.din[15:0]}};
            end
            SZ_WORD: begin
                be_c    = 4'b1111;
                wdata_c = cur_rec.din;
            end
            default: begin
                be_c    = 4'b0000;
                wdata_c = cur_rec.din;
            end
        endcase
    end

    // memory is driven only while in MA_ACCESS and never for a bad access
    assign mem_go    = (state == MA_ACCESS) && is_mem && !acc_err_c;
    assign mem_en    = mem_go;
    assign mem_we    = mem_go && (cur_rec.kind == ACC_STORE);
    assign mem_idx   = cur_rec.ans[MEM_IDX_W+1:2];
    assign mem_be    = be_c;
    assign mem_wdata = wdata_c;

    // pick the addressed lane, then extend
    assign load_byte   = mem_rdata[{byte_off, 3'b000} +: 8];
    assign load_half   = byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];
    assign load_signed = (cur_rec.kind == ACC_LOAD_S);

    always_comb begin
        case (cur_rec.size)
            SZ_BYTE: load_val = {{(DATA_W-8){load_signed & load_byte[7]}}, load_byte};
            SZ_HALF: load_val = {{(DATA_W-16){load_signed & load_half[15]}}, load_half};
            default: load_val = mem_rdata;
        endcase
    end

    always_comb begin
        case (cur_rec.kind)
            ACC_NONE:  wb_val = cur_rec.ans;
            ACC_STORE: wb_val = '0;
            default:   wb_val = load_val;
        endcase
    end

    // stores and failed accesses never write a register
    assign wb_en_c = cur_rec.wb_en && (cur_rec.kind != ACC_STORE) && !acc_err_c;

    // control FSM and both handshakes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= MA_IDLE;
            up_ack     <= 1'b0;
            down_syn   <= 1'b0;
            access_err <= 1'b0;
        end else begin
            access_err <= 1'b0;
            if (up_ack && !up_syn) begin
                up_ack <= 1'b0;
            end
            case (state)
                MA_IDLE: begin
                    if (accept) begin
                        up_ack <= 1'b1;
                        state  <= MA_ACCESS;
                    end
                end
                MA_ACCESS: begin
                    state <= MA_RESULT;
                end
                MA_RESULT: begin
                    // read data is on mem_rdata now
                    down_syn   <= 1'b1;
                    access_err <= acc_err_c;
                    state      <= MA_WAIT_ACK;
                end
                MA_WAIT_ACK: begin
                    if (down_ack) begin
                        down_syn <= 1'b0;
                        state    <= MA_WAIT_UP;
                    end
                end
                MA_WAIT_UP: begin
                    if (!down_ack && !up_syn) begin
                        state <= MA_IDLE;
                    end
                end
                default: state <= MA_IDLE;
            endcase
        end
    end

    // captured instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_rec <= up_rec;
        end
    end

    // writeback record, held until the handshake is done
    always_ff @(posedge clk) begin
        if (state == MA_RESULT) begin
            down_rec.wb_en <= wb_en_c;
            down_rec.rd    <= cur_rec.rd;
            down_rec.value <= wb_val;
        end
    end

endmodule

// File: wb_regfile.sv
`timescale 1ns/1ps

module wb_regfile import ma_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // writeback link from the stage
    input  logic     down_syn,
    input  ma_wb_t   down_rec,
    output logic     down_ack,

    // read port
    input  reg_idx_t rf_raddr,
    output data_t    rf_rdata
);

    data_t regs [REG_COUNT];
    logic  take;

    // a record is taken once per handshake
    assign take = down_syn && !down_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            down_ack <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (take) begin
                down_ack <= 1'b1;
                // r0 stays zero
                if (down_rec.wb_en && (down_rec.rd != '0)) begin
                    regs[down_rec.rd] <= down_rec.value;
                end
            end else if (down_ack && !down_syn) begin
                down_ack <= 1'b0;
            end
        end
    end

    assign rf_rdata = regs[rf_raddr];

endmodule

// File: ma_subsys_top.sv
`timescale 1ns/1ps

module ma_subsys_top import ma_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     up_syn,
    input  ex_ma_t   up_rec,
    output logic     up_ack,

    input  reg_idx_t rf_raddr,
    output data_t    rf_rdata,

    output logic     access_err
);

    // stage to register file
    logic     down_syn;
    logic     down_ack;
    ma_wb_t   down_rec;

    // stage to data memory
    logic     mem_en;
    logic     mem_we;
    mem_idx_t mem_idx;
    byte_en_t mem_be;
    data_t    mem_wdata;
    data_t    mem_rdata;

    ma_stage ma_stage_i (
        .clk        (clk),
        .rst        (rst),
        .up_syn     (up_syn),
        .up_rec     (up_rec),
        .up_ack     (up_ack),
        .down_syn   (down_syn),
        .down_rec   (down_rec),
        .down_ack   (down_ack),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_idx    (mem_idx),
        .mem_be     (mem_be),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .access_err (access_err)
    );

    data_mem data_mem_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_idx   (mem_idx),
        .mem_be    (mem_be),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    wb_regfile wb_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .down_syn (down_syn),
        .down_rec (down_rec),
        .down_ack (down_ack),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

endmodule

// File: tb_ma_subsys.sv
`timescale 1ns/1ps

module tb_ma_subsys import ma_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    // upper bound on the operations sent over all tests
    localparam int N_OPS      = 100;
    localparam int HS_LIMIT   = 50;

    logic     clk;
    logic     rst;
    logic     up_syn;
    ex_ma_t   up_rec;
    logic     up_ack;
    reg_idx_t rf_raddr;
    data_t    rf_rdata;
    logic     access_err;

    // reference model of the register file and the data memory
    data_t regs_m [REG_COUNT];
    data_t mem_m [int];
    int    errors       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;

    ma_subsys_top ma_subsys_top_i (
        .clk        (clk),
        .rst        (rst),
        .up_syn     (up_syn),
        .up_rec     (up_rec),
        .up_ack     (up_ack),
        .rf_raddr   (rf_raddr),
        .rf_rdata   (rf_rdata),
        .access_err (access_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_OPS * 40 + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog: the run timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %08h, expected %08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_err(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic ex_ma_t make_rec(acc_kind_e kind, acc_size_e size, reg_idx_t rd,
                                        addr_t ans, data_t din);
        ex_ma_t rec;
        rec.kind  = kind;
        rec.size  = size;
        rec.rd    = rd;
        rec.wb_en = 1'b1;
        rec.ans   = ans;
        rec.din   = din;
        return rec;
    endfunction

    // one upstream four-phase transfer, access_err watched until the stage is idle again
    task automatic send_op(input ex_ma_t rec, output logic err_seen);
        int waited;
        waited   = 0;
        err_seen = 1'b0;
        @(negedge clk);
        up_rec = rec;
        up_syn = 1'b1;
        while (up_ack !== 1'b1 && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (up_ack !== 1'b1) begin
            $display("%0t: up_ack never rose, the stage did not take the operation", $time);
            errors++;
        end
        up_syn = 1'b0;
        // stage is back in idle six edges after the capture
        repeat (6) begin
            @(negedge clk);
            err_seen = err_seen | access_err;
        end
    endtask

    task automatic read_reg(input reg_idx_t idx, output data_t val);
        @(negedge clk);
        rf_raddr = idx;
        #5;
        val = rf_rdata;
    endtask

    // little-endian lanes, loads extend by kind, bad accesses change nothing
    task automatic update_model(input ex_ma_t rec, output logic exp_err);
        int          idx;
        int          off;
        data_t       word;
        data_t       val;
        logic [7:0]  b;
        logic [15:0] h;
        idx = int'((rec.ans >> 2) % MEM_WORDS);
        off = int'(rec.ans[1:0]);
        case (rec.size)
            SZ_BYTE: exp_err = 1'b0;
            SZ_HALF: exp_err = (off % 2) != 0;
            SZ_WORD: exp_err = off != 0;
            default: exp_err = 1'b1;
        endcase
        if (rec.kind == ACC_NONE) begin
            exp_err = 1'b0;
        end
        if (!exp_err) begin
            word = mem_m.exists(idx) ? mem_m[idx] : 'x;
            b    = word[off*8 +: 8];
            h    = word[(off/2)*16 +: 16];
            case (rec.size)
                SZ_BYTE: val = (rec.kind == ACC_LOAD_S) ? {{24{b[7]}}, b} : {24'h0, b};
                SZ_HALF: val = (rec.kind == ACC_LOAD_S) ? {{16{h[15]}}, h} : {16'h0, h};
                default: val = word;
            endcase
            if (rec.kind == ACC_NONE) begin
                val = rec.ans;
            end
            if (rec.kind == ACC_STORE) begin
                case (rec.size)
                    SZ_BYTE: word[off*8 +: 8] = rec.din[7:0];
                    SZ_HALF: word[(off/2)*16 +: 16] = rec.din[15:0];
                    default: word = rec.din;
                endcase
                mem_m[idx] = word;
            end else if (rec.wb_en && rec.rd != 0) begin
                regs_m[rec.rd] = val;
            end
        end
    endtask

    task automatic run_op(input ex_ma_t rec);
        logic  err_seen;
        logic  exp_err;
        data_t got;
        send_op(rec, err_seen);
        update_model(rec, exp_err);
        check_err("access_err", err_seen, exp_err);
        read_reg(rec.rd, got);
        check_data($sformatf("r%0d", rec.rd), got, regs_m[rec.rd]);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, errors - errs_before);
        end
    endtask

    task automatic test_reset_nop();
        int    e;
        data_t got;
        e = errors;
        for (int i = 0; i < REG_COUNT; i++) begin
            read_reg(reg_idx_t'(i), got);
            check_data($sformatf("r%0d after reset", i), got, '0);
        end
        for (int i = 1; i <= 5; i++) begin
            run_op(make_rec(ACC_NONE, SZ_WORD, reg_idx_t'(i), $urandom, '0));
        end
        // r0 ignores the write
        run_op(make_rec(ACC_NONE, SZ_WORD, '0, 32'hdead_beef, '0));
        end_test("reset and no-op", e);
    endtask

    task automatic test_word_round_trip();
        int    e;
        addr_t a [4];
        e = errors;
        for (int i = 0; i < 4; i++) begin
            a[i] = addr_t'((64 + i * 8 + $urandom_range(0, 7)) * 4);
            run_op(make_rec(ACC_STORE, SZ_WORD, '0, a[i], $urandom));
        end
        for (int i = 0; i < 4; i++) begin
            run_op(make_rec(ACC_LOAD_S, SZ_WORD, reg_idx_t'(10 + i), a[i], '0));
            run_op(make_rec(ACC_LOAD_U, SZ_WORD, reg_idx_t'(20 + i), a[i], '0));
        end
        end_test("word round trip", e);
    endtask

    task automatic test_byte_half_lanes();
        int    e;
        data_t got;
        e = errors;
        run_op(make_rec(ACC_STORE, SZ_WORD, '0, 32'd160, 32'h1122_3344));
        run_op(make_rec(ACC_STORE, SZ_BYTE, '0, 32'd161, 32'h0000_00ab));
        run_op(make_rec(ACC_STORE, SZ_HALF, '0, 32'd162, 32'h0000_cdef));
        run_op(make_rec(ACC_LOAD_U, SZ_WORD, 5'd9, 32'd160, '0));
        // byte 1 and the upper half replaced, byte 0 kept
        read_reg(5'd9, got);
        check_data("merged lanes", got, 32'hcdef_ab44);
        end_test("byte and half lanes", e);
    endtask

    task automatic test_extension();
        int e;
        e = errors;
        run_op(make_rec(ACC_STORE, SZ_WORD, '0, 32'd200, 32'h80f0_7f85));
        run_op(make_rec(ACC_LOAD_S, SZ_BYTE, 5'd11, 32'd200, '0));
        run_op(make_rec(ACC_LOAD_U, SZ_BYTE, 5'd12, 32'd200, '0));
        run_op(make_rec(ACC_LOAD_S, SZ_BYTE, 5'd13, 32'd203, '0));
        run_op(make_rec(ACC_LOAD_S, SZ_HALF, 5'd14, 32'd202, '0));
        run_op(make_rec(ACC_LOAD_U, SZ_HALF, 5'd15, 32'd202, '0));
        end_test("load extension", e);
    endtask

    task automatic test_errors();
        int e;
        e = errors;
        run_op(make_rec(ACC_STORE, SZ_WORD, '0, 32'd240, 32'h5a5a_c3c3));
        run_op(make_rec(ACC_NONE, SZ_WORD, 5'd7, 32'h0bad_cafe, '0));
        run_op(make_rec(ACC_LOAD_S, SZ_HALF, 5'd7, 32'd241, '0));
        run_op(make_rec(ACC_STORE, SZ_WORD, '0, 32'd242, 32'hffff_ffff));
        run_op(make_rec(ACC_LOAD_U, SZ_BAD, 5'd7, 32'd240, '0));
        // memory word must still hold the first store
        run_op(make_rec(ACC_LOAD_U, SZ_WORD, 5'd8, 32'd240, '0));
        end_test("access errors", e);
    endtask

    task automatic test_back_to_back();
        int     e;
        ex_ma_t rec;
        e = errors;
        for (int i = 0; i < 8; i++) begin
            run_op(make_rec(ACC_STORE, SZ_WORD, '0, addr_t'((16 + i) * 4), $urandom));
        end
        for (int i = 0; i < 40; i++) begin
            rec = make_rec(acc_kind_e'($urandom_range(0, 3)), acc_size_e'($urandom_range(0, 3)),
                           reg_idx_t'($urandom_range(0, 31)), $urandom, $urandom);
            rec.wb_en = ($urandom_range(0, 7) != 0);
            if (rec.kind != ACC_NONE) begin
                rec.ans = addr_t'((16 + $urandom_range(0, 7)) * 4 + $urandom_range(0, 3));
            end
            repeat ($urandom_range(0, 3)) @(negedge clk);
            run_op(rec);
        end
        for (int i = 0; i < 8; i++) begin
            run_op(make_rec(ACC_LOAD_U, SZ_WORD, 5'd1, addr_t'((16 + i) * 4), '0));
        end
        end_test("back-to-back", e);
    endtask

    initial begin
        void'($urandom(24));
        rst      = 1'b1;
        up_syn   = 1'b0;
        up_rec   = '0;
        rf_raddr = '0;
        foreach (regs_m[i]) begin
            regs_m[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_nop();
        test_word_round_trip();
        test_byte_half_lanes();
        test_extension();
        test_errors();
        test_back_to_back();
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
ma_pkg.sv
data_mem.sv
ma_stage.sv
wb_regfile.sv
ma_subsys_top.sv
tb_ma_subsys.sv

// File: Bender.yml
package:
  name: ma_subsys

dependencies: {}

sources:
  - ma_pkg.sv
  - data_mem.sv
  - ma_stage.sv
  - wb_regfile.sv
  - ma_subsys_top.sv
  - target: test
    files:
      - tb_ma_subsys.sv
